//--- flist.f
mmu_pkg.sv
mmu_tlb.sv
mmu_ptw.sv
mmu_perm_check.sv
mmu_apb_regs.sv
mmu_top.sv
tb_mmu_top.sv

//--- tb_mmu_top.sv
`default_nettype none

module tb_mmu_top
	import mmu_pkg::*;
;

	localparam int          ENTRIES   = 32;
	localparam int          NUM_TESTS = 6;
	localparam logic [21:0] ROOT_PPN  = 22'h00100;
	localparam logic [31:0] SATP_ON   = {1'b1, 9'b0, ROOT_PPN};

	logic              clk = 1'b0;
	logic              rst_n;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [APB_AW-1:0] paddr;
	logic [31:0]       pwdata;
	logic [31:0]       prdata;
	logic              pready;
	logic              pslverr;
	mem_req_t          mem_req;
	mem_rsp_t          mem_rsp;

	pte_t        pt_mem [logic [33:0]];   // Sparse page table memory.
	int unsigned mem_reads;
	int          errors;
	int          tests_run;
	int          tests_failed;
	logic        slverr_seen;             // pslverr of the last access phase.

	// Permission cases: leaf tag, access type and user bit.
	logic [7:0]  perm_tags [11] = '{8'h43, 8'h43, 8'h47, 8'hC7, 8'h49,
		8'h49, 8'h03, 8'h53, 8'h53, 8'h43, 8'h43};
	logic [1:0]  perm_acc  [11] = '{2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd0,
		2'd0, 2'd0, 2'd0, 2'd0, 2'd2};
	logic [10:0] perm_user = 11'b010_1000_0000;   // Bit i is case i.

	mmu_top #(.ENTRIES(ENTRIES)) u_mmu_top (
		.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .mem_req(mem_req), .mem_rsp(mem_rsp)
	);

	always #20 clk = ~clk;

	// Memory answers each held request after 1 to 4 cycles.
	initial begin : mem_model
		int          delay;
		logic [33:0] addr;
		void'($urandom(32'h467));
		mem_rsp   = '0;
		mem_reads = 0;
		forever begin
			@(posedge clk);
			if (rst_n && mem_req.valid) begin
				addr  = mem_req.addr;
				delay = 1 + ($urandom % 4);
				repeat (delay - 1) @(posedge clk);
				mem_rsp.valid <= 1'b1;
				mem_rsp.data  <= pt_mem.exists(addr) ? pt_mem[addr] : pte_t'('0);
				mem_reads++;
				@(posedge clk);
				mem_rsp <= '0;
			end
		end
	end

	initial begin : watchdog
		repeat (NUM_TESTS * 200) @(posedge clk);
		$display("Timeout: the tests did not finish in %0d cycles", NUM_TESTS * 200);
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic logic [33:0] pte_addr(input logic [21:0] table_ppn,
		input logic [9:0] idx);
		return {table_ppn, idx, 2'b00};
	endfunction

	task automatic put_pte(input logic [21:0] table_ppn, input logic [9:0] idx,
		input logic [21:0] ppn, input logic [7:0] tag);
		pte_t p;
		p.ppn1 = ppn[21:10];
		p.ppn0 = ppn[9:0];
		p.rsw  = 2'b00;
		p.tag  = access_tag_t'(tag);
		pt_mem[pte_addr(table_ppn, idx)] = p;
	endtask

	// Expected fault from the leaf bits, access type and privilege.
	function automatic logic expect_fault(input access_tag_t t, input access_e acc,
		input logic user);
		logic f;
		f = !t.v || !t.a;
		if (acc == ACC_READ && !t.r)
			f = 1'b1;
		if (acc == ACC_WRITE && (!t.w || !t.d))
			f = 1'b1;
		if (acc == ACC_EXEC && !t.x)
			f = 1'b1;
		if (user != t.u)
			f = 1'b1;   // User needs u, supervisor needs it clear.
		return f;
	endfunction

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		slverr_seen = pslverr;
		check_flag("pready", pready, 1'b1);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		data = prdata;   // Access phase value.
		slverr_seen = pslverr;
		check_flag("pready", pready, 1'b1);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_result(input string name, input xlate_res_t got,
		input xlate_res_t exp);
		if (got !== exp) begin
			$display("FAILED %s: ppn=%h fault=%h walked=%h, expected ppn=%h fault=%h walked=%h",
				name, got.ppn, got.fault, got.walked, exp.ppn, exp.fault, exp.walked);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Issues one translation and waits for STATUS.done.
	task automatic translate(input logic [19:0] vpn, input access_e acc, input logic user,
		output xlate_res_t res);
		logic [31:0] status;
		logic [31:0] result;
		int          polls;
		polls = 0;
		apb_write(REG_VADDR, {vpn, 12'h000});
		apb_write(REG_CMD, {28'b0, 1'b0, user, acc});
		do begin
			apb_read(REG_STATUS, status);
			polls++;
		end while ((status[0] || !status[1]) && polls < 40);
		if (status[0] || !status[1]) begin
			$display("Translation of vpn %h never reported done", vpn);
			errors++;
		end
		apb_read(REG_RESULT, result);
		res = '{ppn: result[21:0], fault: status[2], walked: status[3]};
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors != errs_before) begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors - errs_before);
		end else begin
			$display("Test %s: ok", name);
		end
	endtask

	task automatic bypass_mode();
		int          e0;
		int unsigned r0;
		xlate_res_t  res;
		logic [31:0] satp;
		logic [31:0] unmapped;
		e0 = errors;
		r0 = mem_reads;
		apb_write(REG_SATP, {10'b0, ROOT_PPN});   // Mode bit clear.
		check_flag("pslverr", slverr_seen, 1'b0);
		apb_read(REG_SATP, satp);
		check_flag("pslverr", slverr_seen, 1'b0);
		check_word("satp", satp, {10'b0, ROOT_PPN});
		apb_read(8'h14, unmapped);   // No register at this offset.
		check_flag("pslverr", slverr_seen, 1'b1);
		translate(20'h12345, ACC_READ, 1'b0, res);
		check_result("bypass", res, '{ppn: 22'h012345, fault: 1'b0, walked: 1'b0});
		check_word("mem_reads", mem_reads - r0, 0);
		finish_test("bypass", e0);
	endtask

	task automatic miss_then_hit();
		int          e0;
		int unsigned r0;
		xlate_res_t  res;
		e0 = errors;
		put_pte(ROOT_PPN, 10'd1, 22'h00200, 8'h01);   // Pointer to L0 table.
		put_pte(22'h00200, 10'd1, 22'h0ABCD, 8'hC7);
		apb_write(REG_SATP, SATP_ON);
		r0 = mem_reads;
		translate(20'h00401, ACC_READ, 1'b0, res);
		check_result("first", res, '{ppn: 22'h0ABCD, fault: 1'b0, walked: 1'b1});
		check_word("mem_reads", mem_reads - r0, 2);
		r0 = mem_reads;
		translate(20'h00401, ACC_READ, 1'b0, res);
		check_result("repeat", res, '{ppn: 22'h0ABCD, fault: 1'b0, walked: 1'b0});
		check_word("mem_reads", mem_reads - r0, 0);
		finish_test("miss_then_hit", e0);
	endtask

	task automatic megapage_leaf();
		int          e0;
		int unsigned r0;
		xlate_res_t  res;
		e0 = errors;
		put_pte(ROOT_PPN, 10'd2, 22'h003C00, 8'h4B);   // Leaf at L1.
		r0 = mem_reads;
		translate({10'd2, 10'h155}, ACC_EXEC, 1'b0, res);
		check_result("megapage", res, '{ppn: {12'h00F, 10'h155}, fault: 1'b0, walked: 1'b1});
		check_word("mem_reads", mem_reads - r0, 1);
		finish_test("megapage", e0);
	endtask

	task automatic permission_table();
		int         e0;
		xlate_res_t res;
		xlate_res_t exp;
		e0 = errors;
		put_pte(ROOT_PPN, 10'd3, 22'h00300, 8'h01);
		for (int i = 0; i < 11; i++) begin
			put_pte(22'h00300, 10'(8 + i), 22'h01000 + 22'(i), perm_tags[i]);
			translate({10'd3, 10'(8 + i)}, access_e'(perm_acc[i]), perm_user[i], res);
			exp.ppn    = 22'h01000 + 22'(i);
			exp.fault  = expect_fault(access_tag_t'(perm_tags[i]), access_e'(perm_acc[i]),
				perm_user[i]);
			exp.walked = 1'b1;
			check_result($sformatf("perm case %0d", i), res, exp);
		end
		finish_test("permissions", e0);
	endtask

	task automatic walk_faults();
		int          e0;
		int unsigned r0;
		xlate_res_t  res;
		e0 = errors;
		r0 = mem_reads;
		translate({10'd5, 10'h004}, ACC_READ, 1'b0, res);   // No L1 entry there.
		check_result("invalid L1", res, '{ppn: 22'h0, fault: 1'b1, walked: 1'b1});
		check_word("mem_reads", mem_reads - r0, 1);
		put_pte(ROOT_PPN, 10'd6, 22'h00600, 8'h01);
		put_pte(22'h00600, 10'h006, 22'h00700, 8'h01);
		r0 = mem_reads;
		translate({10'd6, 10'h006}, ACC_READ, 1'b0, res);
		check_result("pointer at L0", res, '{ppn: 22'h0, fault: 1'b1, walked: 1'b1});
		check_word("mem_reads", mem_reads - r0, 2);
		finish_test("walk_faults", e0);
	endtask

	task automatic flush_and_replace();
		int          e0;
		int unsigned r0;
		xlate_res_t  res;
		logic [31:0] status;
		e0 = errors;
		translate(20'h00401, ACC_READ, 1'b0, res);
		check_result("before flush", res, '{ppn: 22'h0ABCD, fault: 1'b0, walked: 1'b0});
		apb_write(REG_CMD, 32'h8);
		apb_read(REG_STATUS, status);
		check_word("status", status & 32'hF, 32'h2);
		r0 = mem_reads;
		translate(20'h00401, ACC_READ, 1'b0, res);
		check_result("after flush", res, '{ppn: 22'h0ABCD, fault: 1'b0, walked: 1'b1});
		check_word("mem_reads", mem_reads - r0, 2);
		r0 = mem_reads;
		translate({10'd2, 10'h001}, ACC_READ, 1'b0, res);   // Same index, other tag.
		check_result("alias", res, '{ppn: {12'h00F, 10'h001}, fault: 1'b0, walked: 1'b1});
		check_word("mem_reads", mem_reads - r0, 1);
		r0 = mem_reads;
		translate(20'h00401, ACC_READ, 1'b0, res);
		check_result("replaced", res, '{ppn: 22'h0ABCD, fault: 1'b0, walked: 1'b1});
		check_word("mem_reads", mem_reads - r0, 2);
		finish_test("flush", e0);
	endtask

	initial begin
		rst_n        = 1'b0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		slverr_seen  = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		bypass_mode();
		miss_then_hit();
		megapage_leaf();
		permission_table();
		walk_faults();
		flush_and_replace();
		$display("Tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mmu_top.sv
`default_nettype none

module mmu_top
	import mmu_pkg::*;
#(
	parameter int ENTRIES = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [APB_AW-1:0] paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	output mem_req_t          mem_req,
	input  mem_rsp_t          mem_rsp
);

	logic        tlb_resolve;
	logic        tlb_write_sel;
	logic        tlb_write;
	logic        tlb_flush;
	logic        tlb_enable;
	logic [19:0] tlb_vpn;
	logic        tlb_done;
	logic        tlb_miss;
	access_tag_t tlb_tag;
	logic [21:0] tlb_phys;
	xlate_req_t  req;
	xlate_res_t  res;
	logic [21:0] root_ppn;
	logic        walked;
	logic        walk_start;
	logic        walk_done;
	logic        walk_fault;
	logic        ptw_fill;
	access_tag_t ptw_tag;
	logic [21:0] ptw_phys;

	// Refill only lands while the sequencer waits on the walker.
	assign tlb_write = ptw_fill && tlb_write_sel;

	mmu_apb_regs #(.ENTRIES(ENTRIES)) u_regs (
		.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .tlb_resolve(tlb_resolve), .tlb_write_sel(tlb_write_sel),
		.tlb_flush(tlb_flush), .tlb_enable(tlb_enable), .tlb_vpn(tlb_vpn),
		.tlb_done(tlb_done), .tlb_miss(tlb_miss), .res(res), .req(req),
		.root_ppn(root_ppn), .walked(walked), .walk_start(walk_start),
		.walk_done(walk_done), .walk_fault(walk_fault)
	);

	mmu_tlb #(.ENTRIES(ENTRIES)) u_tlb (
		.clk(clk), .rst_n(rst_n), .enable(tlb_enable), .vpn(tlb_vpn),
		.resolve(tlb_resolve), .write(tlb_write), .flush(tlb_flush),
		.wr_tag(ptw_tag), .wr_phys(ptw_phys), .done(tlb_done), .miss(tlb_miss),
		.tag(tlb_tag), .phys(tlb_phys)
	);

	mmu_ptw u_ptw (
		.clk(clk), .rst_n(rst_n), .start(walk_start), .req(req), .root_ppn(root_ppn),
		.mem_req(mem_req), .mem_rsp(mem_rsp), .fill(ptw_fill), .fill_tag(ptw_tag),
		.fill_phys(ptw_phys), .done(walk_done), .fault(walk_fault)
	);

	mmu_perm_check u_perm (
		.tag(tlb_tag), .phys(tlb_phys), .req(req), .walked(walked), .res(res)
	);

endmodule

`default_nettype wire

//--- mmu_apb_regs.sv
`default_nettype none

module mmu_apb_regs
	import mmu_pkg::*;
#(
	parameter int ENTRIES = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [APB_AW-1:0] paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	output logic              tlb_resolve,
	output logic              tlb_write_sel,
	output logic              tlb_flush,
	output logic              tlb_enable,
	output logic [19:0]       tlb_vpn,
	input  logic              tlb_done,
	input  logic              tlb_miss,
	input  xlate_res_t        res,
	output xlate_req_t        req,
	output logic [21:0]       root_ppn,
	output logic              walked,
	output logic              walk_start,
	input  logic              walk_done,
	input  logic              walk_fault
);

	localparam int IDX_W = $clog2(ENTRIES);

	seq_state_e  state;
	logic        access;
	logic        reg_hit;
	logic        cmd_wr;
	logic        busy;
	logic        satp_mode;
	logic [21:0] satp_ppn;
	logic [31:0] vaddr;
	xlate_req_t  req_q;
	logic        done_q;
	logic        fault_q;
	logic        walked_q;
	logic [21:0] result_ppn;

	assign access  = psel && penable;
	assign reg_hit = (paddr == REG_SATP) || (paddr == REG_VADDR) || (paddr == REG_CMD) ||
		(paddr == REG_STATUS) || (paddr == REG_RESULT);
	assign pready  = 1'b1;
	assign pslverr = access && !reg_hit;
	assign busy    = (state != SEQ_IDLE);
	assign cmd_wr  = access && pwrite && (paddr == REG_CMD) && !busy;   // Dropped while busy.

	always_comb begin
		case (paddr)
			REG_SATP:   prdata = {satp_mode, 9'b0, satp_ppn};
			REG_VADDR:  prdata = vaddr;
			REG_STATUS: prdata = {16'b0, 8'(IDX_W), 4'b0, walked_q, fault_q, done_q, busy};
			REG_RESULT: prdata = {10'b0, result_ppn};
			default:    prdata = 32'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			satp_mode <= 1'b0;
			satp_ppn  <= '0;
			vaddr     <= '0;
		end else if (access && pwrite) begin
			if (paddr == REG_SATP) begin
				satp_mode <= pwdata[31];
				satp_ppn  <= pwdata[21:0];
			end
			if (paddr == REG_VADDR) begin
				vaddr <= pwdata;
			end
		end
	end

	// Translation sequencer.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= SEQ_IDLE;
			done_q   <= 1'b0;
			fault_q  <= 1'b0;
			walked_q <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (cmd_wr) begin
						done_q   <= pwdata[3];        // Flush is done at once.
						fault_q  <= 1'b0;
						walked_q <= 1'b0;
						if (!pwdata[3]) begin
							state <= SEQ_RESOLVE;
						end
					end
				end
				SEQ_RESOLVE: begin
					state <= SEQ_WAIT;
				end
				SEQ_WAIT: begin
					if (tlb_done && tlb_miss) begin
						walked_q <= 1'b1;
						state    <= SEQ_WALK;
					end else if (tlb_done) begin
						done_q  <= 1'b1;
						fault_q <= res.fault && satp_mode;   // Bare mode never faults.
						state   <= SEQ_IDLE;
					end
				end
				SEQ_WALK: begin
					if (walk_done && walk_fault) begin
						done_q  <= 1'b1;
						fault_q <= 1'b1;
						state   <= SEQ_IDLE;
					end else if (walk_done) begin
						state <= SEQ_RESOLVE;         // Look up the refilled entry.
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_wr && !pwdata[3]) begin
			req_q <= '{vpn: vaddr[31:12], access: access_e'(pwdata[1:0]), user: pwdata[2]};
		end
		if (state == SEQ_WAIT && tlb_done && !tlb_miss) begin
			result_ppn <= res.ppn;
		end else if (state == SEQ_WALK && walk_done && walk_fault) begin
			result_ppn <= '0;
		end
	end

	assign tlb_resolve   = (state == SEQ_RESOLVE);
	assign tlb_write_sel = (state == SEQ_WALK);   // Walker owns the write port.
	assign tlb_flush     = cmd_wr && pwdata[3];
	assign tlb_enable    = satp_mode;
	assign tlb_vpn       = req_q.vpn;
	assign req           = req_q;
	assign root_ppn      = satp_ppn;
	assign walked        = walked_q;
	assign walk_start    = (state == SEQ_WAIT) && tlb_done && tlb_miss;

endmodule

`default_nettype wire

//--- mmu_perm_check.sv
`default_nettype none

module mmu_perm_check
	import mmu_pkg::*;
(
	input  access_tag_t tag,
	input  logic [21:0] phys,
	input  xlate_req_t  req,
	input  logic        walked,
	output xlate_res_t  res
);

	logic acc_fault;
	logic priv_fault;
	logic fault;

	// Access type against r, w, x and d.
	always_comb begin
		case (req.access)
			ACC_READ: begin
				acc_fault = !tag.r;
			end
			ACC_WRITE: begin
				acc_fault = !tag.w || !tag.d;   // No hardware D update.
			end
			ACC_EXEC: begin
				acc_fault = !tag.x;
			end
			default: begin
				acc_fault = 1'b1;
			end
		endcase
	end

	// User may only touch u pages, supervisor never.
	always_comb begin
		if (req.user) begin
			priv_fault = !tag.u;
		end else begin
			priv_fault = tag.u;
		end
	end

	// A clear A bit faults too.
	assign fault = !tag.v || !tag.a || acc_fault || priv_fault;

	always_comb begin
		res.ppn    = phys;
		res.fault  = fault;
		res.walked = walked;
	end

endmodule

`default_nettype wire

//--- mmu_ptw.sv
`default_nettype none

module mmu_ptw
	import mmu_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  xlate_req_t  req,
	input  logic [21:0] root_ppn,
	output mem_req_t    mem_req,
	input  mem_rsp_t    mem_rsp,
	output logic        fill,
	output access_tag_t fill_tag,
	output logic [21:0] fill_phys,
	output logic        done,
	output logic        fault
);

	ptw_state_e state;
	ptw_state_e state_nx;

	pte_t pte;
	logic pte_bad;
	logic pte_leaf;

	logic [19:0] vpn_q;
	logic [33:0] addr_q;
	access_tag_t tag_q;
	logic [21:0] phys_q;

	// Decode of the returned entry.
	assign pte      = mem_rsp.data;
	assign pte_bad  = !pte.tag.v || (pte.tag.w && !pte.tag.r);
	assign pte_leaf = pte.tag.r || pte.tag.x;

	always_comb begin
		state_nx = state;
		case (state)
			PTW_IDLE: begin
				if (start) begin
					state_nx = PTW_L1_REQ;
				end
			end
			PTW_L1_REQ: begin
				if (mem_rsp.valid) begin
					if (pte_bad) begin
						state_nx = PTW_FAULT;
					end else if (pte_leaf) begin
						state_nx = PTW_FILL;    // Megapage.
					end else begin
						state_nx = PTW_L0_REQ;
					end
				end
			end
			PTW_L0_REQ: begin
				if (mem_rsp.valid) begin
					// A pointer at the last level is invalid.
					if (pte_bad || !pte_leaf) begin
						state_nx = PTW_FAULT;
					end else begin
						state_nx = PTW_FILL;
					end
				end
			end
			default: begin
				state_nx = PTW_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= PTW_IDLE;
		end else begin
			state <= state_nx;
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			PTW_IDLE: begin
				if (start) begin
					vpn_q  <= req.vpn;
					addr_q <= {root_ppn, req.vpn[19:10], 2'b00};
				end
			end
			PTW_L1_REQ: begin
				if (mem_rsp.valid) begin
					addr_q <= {pte.ppn1, pte.ppn0, vpn_q[9:0], 2'b00};
					tag_q  <= pte.tag;
					phys_q <= {pte.ppn1, vpn_q[9:0]};
				end
			end
			PTW_L0_REQ: begin
				if (mem_rsp.valid) begin
					tag_q  <= pte.tag;
					phys_q <= {pte.ppn1, pte.ppn0};
				end
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		mem_req.valid = (state == PTW_L1_REQ) || (state == PTW_L0_REQ);
		mem_req.addr  = addr_q;    // Held until the response.
	end

	assign fill      = (state == PTW_FILL);
	assign fill_tag  = tag_q;
	assign fill_phys = phys_q;
	assign done      = (state == PTW_FILL) || (state == PTW_FAULT);
	assign fault     = (state == PTW_FAULT);

endmodule

`default_nettype wire

//--- mmu_tlb.sv
`default_nettype none

module mmu_tlb
	import mmu_pkg::*;
#(
	parameter int ENTRIES = 32
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        enable,
	input  logic [19:0] vpn,
	input  logic        resolve,
	input  logic        write,
	input  logic        flush,
	input  access_tag_t wr_tag,
	input  logic [21:0] wr_phys,
	output logic        done,
	output logic        miss,
	output access_tag_t tag,
	output logic [21:0] phys
);

	// Low vpn bits index the table, the upper bits are compared.
	localparam int IDX_W = $clog2(ENTRIES);
	localparam int TAG_W = 20 - IDX_W;

	// Everything allowed, accessed and dirty, not global.
	localparam access_tag_t BYPASS_TAG = 8'b1101_1111;

	logic [ENTRIES-1:0] valid;
	logic [7:1]         perm_mem [ENTRIES];
	logic [TAG_W-1:0]   vtag_mem [ENTRIES];
	logic [21:0]        phys_mem [ENTRIES];

	logic [IDX_W-1:0] wr_index;
	logic [TAG_W-1:0] wr_vtag;
	logic [IDX_W-1:0] rd_index;
	logic [TAG_W-1:0] rd_vtag;

	logic        resolve_q;
	logic        enable_q;
	logic [19:0] vpn_q;
	logic        hit;

	assign wr_index = vpn[IDX_W-1:0];
	assign wr_vtag  = vpn[19:IDX_W];
	assign rd_index = vpn_q[IDX_W-1:0];
	assign rd_vtag  = vpn_q[19:IDX_W];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid     <= '0;
			resolve_q <= 1'b0;
		end else begin
			resolve_q <= resolve;
			if (flush) begin
				valid <= '0;       // Flush all entries.
			end else if (write) begin
				valid[wr_index] <= wr_tag.v;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resolve) begin
			vpn_q    <= vpn;
			enable_q <= enable;
		end
		if (write && !flush) begin
			perm_mem[wr_index] <= wr_tag[7:1];
			vtag_mem[wr_index] <= wr_vtag;
			phys_mem[wr_index] <= wr_phys;
		end
	end

	assign hit = valid[rd_index] && (vtag_mem[rd_index] == rd_vtag);

	always_comb begin
		if (enable_q) begin
			tag  = access_tag_t'({perm_mem[rd_index], valid[rd_index]});
			phys = phys_mem[rd_index];
		end else begin
			tag  = BYPASS_TAG;
			phys = {2'b00, vpn_q};   // Identity mapping.
		end
		done = resolve_q;
		miss = resolve_q && enable_q && !hit;
	end

endmodule

`default_nettype wire

//--- mmu_pkg.sv
`default_nettype none

package mmu_pkg;

	localparam int APB_AW = 8;

	// Register offsets on the APB port.
	localparam logic [APB_AW-1:0] REG_SATP   = 8'h00;
	localparam logic [APB_AW-1:0] REG_VADDR  = 8'h04;
	localparam logic [APB_AW-1:0] REG_CMD    = 8'h08;
	localparam logic [APB_AW-1:0] REG_STATUS = 8'h0C;
	localparam logic [APB_AW-1:0] REG_RESULT = 8'h10;

	// Same layout as the Sv32 PTE low byte.
	typedef struct packed {
		logic d;
		logic a;
		logic g;
		logic u;
		logic x;
		logic w;
		logic r;
		logic v;
	} access_tag_t;

	typedef struct packed {
		logic [11:0] ppn1;
		logic [9:0]  ppn0;
		logic [1:0]  rsw;
		access_tag_t tag;
	} pte_t;

	typedef enum logic [1:0] {
		ACC_READ  = 2'd0,
		ACC_WRITE = 2'd1,
		ACC_EXEC  = 2'd2
	} access_e;

	typedef struct packed {
		logic [19:0] vpn;
		access_e     access;
		logic        user;
	} xlate_req_t;

	typedef struct packed {
		logic [21:0] ppn;
		logic        fault;
		logic        walked;   // Walker ran for this request.
	} xlate_res_t;

	typedef struct packed {
		logic        valid;
		logic [33:0] addr;     // Physical byte address.
	} mem_req_t;

	typedef struct packed {
		logic valid;
		pte_t data;
	} mem_rsp_t;

	typedef enum logic [2:0] {
		PTW_IDLE,
		PTW_L1_REQ,
		PTW_L0_REQ,
		PTW_FILL,
		PTW_FAULT
	} ptw_state_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RESOLVE,
		SEQ_WAIT,
		SEQ_WALK
	} seq_state_e;

endpackage

`default_nettype wire
